// File: hdl/fetchPkg.sv
package fetchPkg;

  // address and data geometry
  localparam int AddrWidth = 32;
  localparam int XLen = 64;
  localparam int OffsetBits = 5;
  localparam int IndexBits = 6;
  localparam int TagBits = 21;
  localparam int NumSets = 64;
  localparam int LineBeats = 4;
  localparam int NumWays = 2;

  // byte offset inside one 64-bit word
  localparam int WordBits = 3;
  localparam int BeatBits = OffsetBits - WordBits;
  localparam int LineBits = LineBeats * XLen;

  // memory side flow control
  localparam int MemCredits = 2;
  localparam int CreditBits = $clog2(MemCredits + 1);

  // victim LFSR start value, must be nonzero
  localparam logic [15:0] LfsrSeed = 16'hACE1;

  typedef enum logic {
    BusReadLine,
    BusReadWord
  } busOpE;

  typedef enum logic {
    PeerIcache,
    PeerUncached
  } peerIdE;

  typedef struct packed {
    logic [AddrWidth-1:0] addr;
  } coreReqT;

  typedef struct packed {
    logic [XLen-1:0] data;
  } coreRespT;

  typedef struct packed {
    logic [AddrWidth-1:0] addr;
    busOpE                op;
    peerIdE               id;
  } memReqT;

  typedef struct packed {
    logic [XLen-1:0] data;
    peerIdE          id;
    logic            last;
  } memRespT;

  typedef enum logic [2:0] {
    CsIdle,
    CsCompare,
    CsMiss,
    CsRefill,
    CsReplace
  } cacheStateE;

endpackage

// File: hdl/wayDataRam.sv
`timescale 1ns/10ps

module wayDataRam
  import fetchPkg::*;
(
  input  logic                 clk,
  input  logic                 en_i,
  input  logic                 we_i,
  input  logic [IndexBits-1:0] index_i,
  input  logic [LineBits-1:0]  wdata_i,
  output logic [LineBits-1:0]  rdata_o
);

  // one full line per entry
  logic [LineBits-1:0] mem [NumSets];

  // single port, write has priority over read
  always_ff @(posedge clk) begin
    if (en_i) begin
      if (we_i) begin
        mem[index_i] <= wdata_i;
      end else begin
        rdata_o <= mem[index_i];
      end
    end
  end

endmodule

// File: hdl/instrCache.sv
`timescale 1ns/10ps

module instrCache
  import fetchPkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     reqValid_i,
  input  coreReqT  req_i,
  output logic     reqReady_o,
  output logic     respValid_o,
  output coreRespT resp_o,
  output logic     busReqValid_o,
  output memReqT   busReq_o,
  input  logic     busGrant_i,
  input  logic     busRespValid_i,
  input  memRespT  busResp_i
);

  cacheStateE state;
  cacheStateE stateNext;

  coreReqT reqQ;
  logic [IndexBits-1:0] reqIndex;
  logic [TagBits-1:0] reqTag;
  logic [BeatBits-1:0] reqBeat;
  logic [IndexBits-1:0] ramIndex;

  logic accept;
  logic inCompare;
  logic hit;
  logic fromBuf;
  logic victim;

  logic [NumWays-1:0] wayValid;
  logic [NumWays-1:0] wayHit;
  logic [NumWays-1:0] wayWe;
  logic [LineBeats-1:0][XLen-1:0] wayRdata [NumWays];
  logic [XLen-1:0] hitData;

  // tag and valid storage, indexed [way][set]
  logic [TagBits-1:0] tagArr [NumWays][NumSets];
  logic [NumSets-1:0] validArr [NumWays];

  logic [LineBeats-1:0][XLen-1:0] refillBuf;
  logic [BeatBits-1:0] beatCnt;
  logic [15:0] lfsr;

  // fields of the latched request
  assign reqIndex = reqQ.addr[OffsetBits +: IndexBits];
  assign reqTag = reqQ.addr[AddrWidth-1 -: TagBits];
  assign reqBeat = reqQ.addr[OffsetBits-1:WordBits];

  assign inCompare = (state == CsCompare);
  assign hit = |wayHit;

  // new requests only in idle or behind a hit
  assign reqReady_o = (state == CsIdle) || (inCompare && hit);
  assign accept = reqValid_i && reqReady_o;
  assign respValid_o = inCompare && hit;

  // read the incoming index when accepting, else stay on the latched line
  assign ramIndex = accept ? req_i.addr[OffsetBits +: IndexBits] : reqIndex;

  for (genvar w = 0; w < NumWays; w++) begin : gWay
    assign wayValid[w] = validArr[w][reqIndex];
    assign wayHit[w] = wayValid[w] && (tagArr[w][reqIndex] == reqTag);
    assign wayWe[w] = (state == CsReplace) && (victim == 1'(w));

    wayDataRam uRam (
      .clk     (clk),
      .en_i    (accept || wayWe[w]),
      .we_i    (wayWe[w]),
      .index_i (ramIndex),
      .wdata_i (refillBuf),
      .rdata_o (wayRdata[w])
    );
  end

  assign hitData = wayHit[1] ? wayRdata[1][reqBeat] : wayRdata[0][reqBeat];

  // right after a refill the RAM output is stale, answer from the buffer
  assign resp_o.data = fromBuf ? refillBuf[reqBeat] : hitData;

  // invalid way first, otherwise pseudo-random
  always_comb begin
    if (!wayValid[0]) begin
      victim = 1'b0;
    end else if (!wayValid[1]) begin
      victim = 1'b1;
    end else begin
      victim = lfsr[0];
    end
  end

  // line fetch request
  assign busReqValid_o = (state == CsMiss);
  assign busReq_o.addr = {reqTag, reqIndex, {OffsetBits{1'b0}}};
  assign busReq_o.op = BusReadLine;
  assign busReq_o.id = PeerIcache;

  always_comb begin
    stateNext = state;
    unique case (state)
      CsIdle: begin
        if (accept) begin
          stateNext = CsCompare;
        end
      end
      CsCompare: begin
        if (!hit) begin
          stateNext = CsMiss;
        end else if (!reqValid_i) begin
          stateNext = CsIdle;
        end
      end
      CsMiss: begin
        if (busGrant_i) begin
          stateNext = CsRefill;
        end
      end
      CsRefill: begin
        if (busRespValid_i && busResp_i.last) begin
          stateNext = CsReplace;
        end
      end
      CsReplace: begin
        stateNext = CsCompare;
      end
      default: begin
        stateNext = CsIdle;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= CsIdle;
      fromBuf <= 1'b0;
      beatCnt <= '0;
      lfsr <= LfsrSeed;
      validArr <= '{default: '0};
    end else begin
      state <= stateNext;
      fromBuf <= (state == CsReplace);
      lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
      if ((state == CsRefill) && busRespValid_i) begin
        beatCnt <= beatCnt + 1'b1;
      end
      if (state == CsReplace) begin
        validArr[victim][reqIndex] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      reqQ <= req_i;
    end
    if ((state == CsRefill) && busRespValid_i) begin
      refillBuf[beatCnt] <= busResp_i.data;
    end
    // tag goes in together with the line
    if (state == CsReplace) begin
      tagArr[victim][reqIndex] <= reqTag;
    end
  end

endmodule

// File: hdl/uncachedReader.sv
`timescale 1ns/10ps

module uncachedReader
  import fetchPkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     reqValid_i,
  input  coreReqT  req_i,
  output logic     reqReady_o,
  output logic     respValid_o,
  output coreRespT resp_o,
  output logic     busReqValid_o,
  output memReqT   busReq_o,
  input  logic     busGrant_i,
  input  logic     busRespValid_i,
  input  memRespT  busResp_i
);

  typedef enum logic {
    UrIdle,
    UrWait
  } readerStateE;

  readerStateE state;
  logic reqSent;
  logic [AddrWidth-1:0] addrQ;

  assign reqReady_o = (state == UrIdle);

  // request stays up until the arbiter takes it
  assign busReqValid_o = (state == UrWait) && !reqSent;
  assign busReq_o = '{addr: addrQ, op: BusReadWord, id: PeerUncached};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= UrIdle;
      reqSent <= 1'b0;
      respValid_o <= 1'b0;
    end else begin
      respValid_o <= 1'b0;
      if (reqValid_i && reqReady_o) begin
        state <= UrWait;
        reqSent <= 1'b0;
      end else if (state == UrWait) begin
        if (busGrant_i) begin
          reqSent <= 1'b1;
        end
        // single beat closes the transaction
        if (busRespValid_i) begin
          state <= UrIdle;
          respValid_o <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reqValid_i && reqReady_o) begin
      addrQ <= {req_i.addr[AddrWidth-1:WordBits], {WordBits{1'b0}}};
    end
    if (busRespValid_i) begin
      resp_o.data <= busResp_i.data;
    end
  end

endmodule

// File: hdl/memBusArbiter.sv
`timescale 1ns/10ps

module memBusArbiter
  import fetchPkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    icReqValid_i,
  input  memReqT  icReq_i,
  output logic    icGrant_o,
  output logic    icRespValid_o,
  output memRespT icResp_o,
  input  logic    ucReqValid_i,
  input  memReqT  ucReq_i,
  output logic    ucGrant_o,
  output logic    ucRespValid_o,
  output memRespT ucResp_o,
  output logic    memReqValid_o,
  output memReqT  memReq_o,
  input  logic    memCredit_i,
  input  logic    memRespValid_i,
  input  memRespT memResp_i
);

  // peer that wins a tie in the next cycle
  peerIdE prio;
  logic [CreditBits-1:0] credits;
  logic canIssue;

  assign canIssue = (credits != '0);

  assign icGrant_o = canIssue && icReqValid_i && (!ucReqValid_i || (prio == PeerIcache));
  assign ucGrant_o = canIssue && ucReqValid_i && (!icReqValid_i || (prio == PeerUncached));

  assign memReqValid_o = icGrant_o || ucGrant_o;
  assign memReq_o = icGrant_o ? icReq_i : ucReq_i;

  // return beats steered by id
  assign icRespValid_o = memRespValid_i && (memResp_i.id == PeerIcache);
  assign ucRespValid_o = memRespValid_i && (memResp_i.id == PeerUncached);
  assign icResp_o = memResp_i;
  assign ucResp_o = memResp_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prio <= PeerIcache;
    end else if (memReqValid_o) begin
      // the loser of this grant goes first next time
      prio <= icGrant_o ? PeerUncached : PeerIcache;
    end
  end

  // issue takes a credit, a returned credit gives one back
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credits <= CreditBits'(MemCredits);
    end else begin
      unique case ({memReqValid_o, memCredit_i})
        2'b10: begin
          credits <= credits - 1'b1;
        end
        2'b01: begin
          credits <= credits + 1'b1;
        end
        default: begin
          credits <= credits;
        end
      endcase
    end
  end

endmodule

// File: hdl/fetchSubsystem.sv
`timescale 1ns/10ps

module fetchSubsystem
  import fetchPkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     iReqValid_i,
  input  coreReqT  iReq_i,
  output logic     iReqReady_o,
  output logic     iRespValid_o,
  output coreRespT iResp_o,
  input  logic     dReqValid_i,
  input  coreReqT  dReq_i,
  output logic     dReqReady_o,
  output logic     dRespValid_o,
  output coreRespT dResp_o,
  output logic     memReqValid_o,
  output memReqT   memReq_o,
  input  logic     memCredit_i,
  input  logic     memRespValid_i,
  input  memRespT  memResp_i
);

  // cache side of the shared bus
  logic icReqValid;
  memReqT icReq;
  logic icGrant;
  logic icRespValid;
  memRespT icResp;

  // uncached side of the shared bus
  logic ucReqValid;
  memReqT ucReq;
  logic ucGrant;
  logic ucRespValid;
  memRespT ucResp;

  instrCache uIcache (
    .clk            (clk),
    .rst_n          (rst_n),
    .reqValid_i     (iReqValid_i),
    .req_i          (iReq_i),
    .reqReady_o     (iReqReady_o),
    .respValid_o    (iRespValid_o),
    .resp_o         (iResp_o),
    .busReqValid_o  (icReqValid),
    .busReq_o       (icReq),
    .busGrant_i     (icGrant),
    .busRespValid_i (icRespValid),
    .busResp_i      (icResp)
  );

  uncachedReader uReader (
    .clk            (clk),
    .rst_n          (rst_n),
    .reqValid_i     (dReqValid_i),
    .req_i          (dReq_i),
    .reqReady_o     (dReqReady_o),
    .respValid_o    (dRespValid_o),
    .resp_o         (dResp_o),
    .busReqValid_o  (ucReqValid),
    .busReq_o       (ucReq),
    .busGrant_i     (ucGrant),
    .busRespValid_i (ucRespValid),
    .busResp_i      (ucResp)
  );

  memBusArbiter uArbiter (
    .clk            (clk),
    .rst_n          (rst_n),
    .icReqValid_i   (icReqValid),
    .icReq_i        (icReq),
    .icGrant_o      (icGrant),
    .icRespValid_o  (icRespValid),
    .icResp_o       (icResp),
    .ucReqValid_i   (ucReqValid),
    .ucReq_i        (ucReq),
    .ucGrant_o      (ucGrant),
    .ucRespValid_o  (ucRespValid),
    .ucResp_o       (ucResp),
    .memReqValid_o  (memReqValid_o),
    .memReq_o       (memReq_o),
    .memCredit_i    (memCredit_i),
    .memRespValid_i (memRespValid_i),
    .memResp_i      (memResp_i)
  );

endmodule

// File: verif/memResponder.sv
`timescale 1ns/10ps

module memResponder
  import fetchPkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    memReqValid_i,
  input  memReqT  memReq_i,
  output logic    memCredit_o,
  output logic    memRespValid_o,
  output memRespT memResp_o,
  output logic    overflow_o
);

  integer seed = 72275;
  memReqT pending [$];
  bit busy;
  int waitCnt;
  int beat;
  int numBeats;

  // memory content as a function of the word index
  function automatic logic [XLen-1:0] mixWord(logic [AddrWidth-1:0] wordIdx);
    logic [XLen-1:0] x;
    x = XLen'(wordIdx) * 64'h9E37_79B9_7F4A_7C15;
    return x ^ (x >> 31) ^ {wordIdx, ~wordIdx};
  endfunction

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pending.delete();
      busy = 1'b0;
      waitCnt = 0;
      beat = 0;
      memCredit_o <= 1'b0;
      memRespValid_o <= 1'b0;
      memResp_o <= '0;
      overflow_o <= 1'b0;
    end else begin
      memCredit_o <= 1'b0;
      memRespValid_o <= 1'b0;
      if (busy && waitCnt > 0) begin
        waitCnt--;
      end else if (busy) begin
        // one beat per cycle, words in address order
        numBeats = (pending[0].op == BusReadLine) ? LineBeats : 1;
        memRespValid_o <= 1'b1;
        memResp_o <= '{data: mixWord((pending[0].addr >> WordBits) + beat),
                       id: pending[0].id,
                       last: (beat == numBeats - 1)};
        beat++;
        // slot freed together with the last beat
        if (beat == numBeats) begin
          memCredit_o <= 1'b1;
          busy = 1'b0;
          pending.delete(0);
        end
      end
      if (memReqValid_i) begin
        if (pending.size() >= MemCredits) begin
          overflow_o <= 1'b1;
        end
        pending.push_back(memReq_i);
      end
      // random delay before each burst
      if (!busy && pending.size() > 0) begin
        busy = 1'b1;
        beat = 0;
        waitCnt = {$random(seed)} % 6;
      end
    end
  end

endmodule

// File: verif/fetchSubsystemTb.sv
`timescale 1ns/10ps

module fetchSubsystemTb
  import fetchPkg::*;
();

  localparam int NumReq = 150;
  localparam int ClkPeriod = 4;
  localparam int ResetCycles = 16;
  // worst case for one miss queued behind the other port
  localparam int MissBound = 40;
  localparam int WatchLimit = (ResetCycles + 2 * NumReq * MissBound) * ClkPeriod;

  logic clk;
  logic rst_n;
  logic iReqValid;
  coreReqT iReq;
  logic iReqReady;
  logic iRespValid;
  coreRespT iResp;
  logic dReqValid;
  coreReqT dReq;
  logic dReqReady;
  logic dRespValid;
  coreRespT dResp;
  logic memReqValid;
  memReqT memReq;
  logic memCredit;
  logic memRespValid;
  memRespT memResp;
  logic memOverflow;

  integer iSeed = 72275;
  integer dSeed = 72275 + 1;

  // one entry per accepted request, oldest first
  logic [AddrWidth-1:0] iAddrQ [$];
  int iTimeQ [$];
  bit iFastQ [$];
  logic [AddrWidth-1:0] dAddrQ [$];

  int cycle = 0;
  int outstanding = 0;
  int lineReqs = 0;
  int wordReqs = 0;
  int iDone = 0;
  int dDone = 0;
  int latency;
  memReqT expReq;
  coreRespT expResp;

  fetchSubsystem UUT (
    .clk            (clk),
    .rst_n          (rst_n),
    .iReqValid_i    (iReqValid),
    .iReq_i         (iReq),
    .iReqReady_o    (iReqReady),
    .iRespValid_o   (iRespValid),
    .iResp_o        (iResp),
    .dReqValid_i    (dReqValid),
    .dReq_i         (dReq),
    .dReqReady_o    (dReqReady),
    .dRespValid_o   (dRespValid),
    .dResp_o        (dResp),
    .memReqValid_o  (memReqValid),
    .memReq_o       (memReq),
    .memCredit_i    (memCredit),
    .memRespValid_i (memRespValid),
    .memResp_i      (memResp)
  );

  memResponder respMem (
    .clk            (clk),
    .rst_n          (rst_n),
    .memReqValid_i  (memReqValid),
    .memReq_i       (memReq),
    .memCredit_o    (memCredit),
    .memRespValid_o (memRespValid),
    .memResp_o      (memResp),
    .overflow_o     (memOverflow)
  );

  function automatic logic [XLen-1:0] mixWord(logic [AddrWidth-1:0] wordIdx);
    logic [XLen-1:0] x;
    x = XLen'(wordIdx) * 64'h9E37_79B9_7F4A_7C15;
    return x ^ (x >> 31) ^ {wordIdx, ~wordIdx};
  endfunction

  // six lines with three of them on set 3 to overflow the two ways
  function automatic logic [AddrWidth-1:0] randomAddr(inout integer s);
    int k;
    logic [IndexBits-1:0] idx;
    k = {$random(s)} % 6;
    idx = (k < 3) ? 6'd3 : ((k < 5) ? 6'd32 : 6'd63);
    return {TagBits'(k * 37 + 1), idx, OffsetBits'($random(s))};
  endfunction

  task automatic stopRun();
    $display("Test failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic reportError(string why);
    $display("Error at %0t: %s", $time, why);
    stopRun();
  endtask

  task automatic checkResp(string sigName, coreRespT got, coreRespT exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, sigName, got.data, exp.data);
      stopRun();
    end
  endtask

  task automatic checkReq(string sigName, memReqT got, memReqT exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got addr %h op %0d id %0d expected addr %h op %0d id %0d",
               $time, sigName, got.addr, got.op, got.id, exp.addr, exp.op, exp.id);
      stopRun();
    end
  endtask

  task automatic checkCount(string sigName, int got, int exp);
    if (got != exp) begin
      $display("Mismatch at %0t: %s got %0d expected %0d", $time, sigName, got, exp);
      stopRun();
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  initial begin : mainFlow
    rst_n <= 1'b0;
    repeat (ResetCycles) @(posedge clk);
    rst_n <= 1'b1;
    wait (iDone == NumReq && dDone == NumReq);
    repeat (4) @(posedge clk);
    checkCount("outstanding", outstanding, 0);
    $display("Test completed successfully");
    $finish;
  end

  initial begin : watchdog
    #(WatchLimit);
    reportError("watchdog expired before all requests were answered");
  end

  initial begin : fetchDriver
    logic [AddrWidth-1:0] addr;
    logic [AddrWidth-1:0] prevAddr;
    bit havePrev;
    int gap;
    iReqValid <= 1'b0;
    iReq <= '0;
    havePrev = 1'b0;
    prevAddr = '0;
    wait (rst_n === 1'b1);
    @(posedge clk);
    for (int n = 0; n < NumReq; n++) begin
      addr = randomAddr(iSeed);
      // often stay on the previous line to get hit streams
      if (havePrev && ($random(iSeed) & 1)) begin
        addr[AddrWidth-1:OffsetBits] = prevAddr[AddrWidth-1:OffsetBits];
      end
      iReqValid <= 1'b1;
      iReq <= '{addr: addr};
      do begin
        @(posedge clk);
      end while (!iReqReady);
      iFastQ.push_back(havePrev && (addr[AddrWidth-1:OffsetBits] ==
                                    prevAddr[AddrWidth-1:OffsetBits]));
      iAddrQ.push_back(addr);
      iTimeQ.push_back(cycle);
      prevAddr = addr;
      havePrev = 1'b1;
      gap = {$random(iSeed)} % 4;
      if (gap != 0) begin
        iReqValid <= 1'b0;
        repeat (gap) @(posedge clk);
      end
    end
    iReqValid <= 1'b0;
  end

  initial begin : readDriver
    logic [AddrWidth-1:0] addr;
    int gap;
    dReqValid <= 1'b0;
    dReq <= '0;
    wait (rst_n === 1'b1);
    @(posedge clk);
    for (int n = 0; n < NumReq; n++) begin
      addr = randomAddr(dSeed);
      dReqValid <= 1'b1;
      dReq <= '{addr: addr};
      do begin
        @(posedge clk);
      end while (!dReqReady);
      dAddrQ.push_back(addr);
      gap = {$random(dSeed)} % 4;
      if (gap != 0) begin
        dReqValid <= 1'b0;
        repeat (gap) @(posedge clk);
      end
    end
    dReqValid <= 1'b0;
  end

  // bus requests belong to the oldest unanswered request of their port
  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (memOverflow) begin
      reportError("memory received a request with all of its slots taken");
    end
    if (memReqValid && memReq.id == PeerIcache) begin
      if (iAddrQ.size() == 0) begin
        reportError("line request issued with no fetch pending");
      end
      expReq = '{addr: {iAddrQ[0][AddrWidth-1:OffsetBits], OffsetBits'(0)},
                 op: BusReadLine, id: PeerIcache};
      checkReq("memReq", memReq, expReq);
      lineReqs++;
    end else if (memReqValid) begin
      if (dAddrQ.size() == 0) begin
        reportError("word request issued with no read pending");
      end
      expReq = '{addr: {dAddrQ[0][AddrWidth-1:WordBits], WordBits'(0)},
                 op: BusReadWord, id: PeerUncached};
      checkReq("memReq", memReq, expReq);
      wordReqs++;
    end
    outstanding = outstanding + int'(memReqValid) - int'(memCredit);
    if (outstanding > MemCredits || outstanding < 0) begin
      reportError("outstanding memory requests left the range 0 to MemCredits");
    end
    if (iRespValid) begin
      if (iAddrQ.size() == 0) begin
        reportError("instruction response with no fetch pending");
      end
      latency = cycle - iTimeQ[0];
      expResp.data = mixWord(iAddrQ[0] >> WordBits);
      checkResp("iResp", iResp, expResp);
      if (iFastQ[0]) begin
        checkCount("hit latency", latency, 1);
      end
      // a hit takes one cycle and anything slower was a miss
      checkCount("line requests", lineReqs, (latency == 1) ? 0 : 1);
      iAddrQ.delete(0);
      iTimeQ.delete(0);
      iFastQ.delete(0);
      lineReqs = 0;
      iDone++;
    end
    if (dRespValid) begin
      if (dAddrQ.size() == 0) begin
        reportError("data response with no read pending");
      end
      expResp.data = mixWord(dAddrQ[0] >> WordBits);
      checkResp("dResp", dResp, expResp);
      checkCount("word requests", wordReqs, 1);
      dAddrQ.delete(0);
      wordReqs = 0;
      dDone++;
    end
  end

endmodule

// File: fetchSubsystem.f
hdl/fetchPkg.sv
hdl/wayDataRam.sv
hdl/instrCache.sv
hdl/uncachedReader.sv
hdl/memBusArbiter.sv
hdl/fetchSubsystem.sv
verif/memResponder.sv
verif/fetchSubsystemTb.sv

// File: Bender.yml
package:
  name: fetchSubsystem

sources:
  - hdl/fetchPkg.sv
  - hdl/wayDataRam.sv
  - hdl/instrCache.sv
  - hdl/uncachedReader.sv
  - hdl/memBusArbiter.sv
  - hdl/fetchSubsystem.sv
  - target: simulation
    files:
      - verif/memResponder.sv
      - verif/fetchSubsystemTb.sv
